//--- source/dcache_pkg.sv
package dcache_pkg;

   // Cache geometry
   localparam int num_ways       = 2;
   localparam int set_width      = 4;
   localparam int num_sets       = 16;
   localparam int word_sel_width = 3;
   localparam int line_bits      = 256;
   localparam int line_bytes     = 32;
   localparam int tag_width      = 23;

   // Word address split into its cache fields
   typedef struct packed {
      logic [tag_width-1:0]      tag;
      logic [set_width-1:0]      set;
      logic [word_sel_width-1:0] word_sel;
   } addr_fields_t;

   // Address bits 31..2, seen either whole or as tag/set/word
   typedef union packed {
      logic [tag_width+set_width+word_sel_width-1:0] word_addr;
      addr_fields_t                                  f;
   } word_addr_t;

   typedef logic [tag_width+set_width-1:0] line_addr_t;
   typedef logic [line_bits-1:0]           line_t;
   typedef logic [3:0]                     byte_en_t;
   typedef logic [line_bytes-1:0]          line_be_t;

   // Level-two arbiter opcodes
   typedef enum logic [2:0] {
      l2_opc_read  = 3'd0,
      l2_opc_write = 3'd1
   } l2_opc_t;

   typedef struct packed {
      logic       valid;
      l2_opc_t    opc;
      line_addr_t addr;
      line_t      wdata;
      line_be_t   wbe;
   } l2_req_t;

   // Idle when re is low and we is all zero
   typedef struct packed {
      logic       re;
      byte_en_t   we;
      word_addr_t addr;
      logic [31:0] wdata;
   } cpu_req_t;

endpackage

//--- source/dcache_ctrl.sv
module dcache_ctrl (
   input  logic                                clkrst_mem_clk,
   input  logic                                clkrst_mem_rst_n,
   input  dcache_pkg::cpu_req_t                cpu_req,
   input  logic                                hit,
   input  logic                                l2_rvalid,
   input  logic                                l2_stall,
   input  dcache_pkg::line_t                   merged_line,
   input  dcache_pkg::line_be_t                line_be,
   output dcache_pkg::cpu_req_t                latched_req,
   output logic [dcache_pkg::set_width-1:0]    ram_set,
   output logic                                fill_we,
   output logic                                wr_we,
   output dcache_pkg::l2_req_t                 issue,
   output logic                                ready
);

   import dcache_pkg::*;

   // rd_pend: line read not yet sent; wr_pend: write-through not yet sent
   logic       rd_pend;
   logic       wr_pend;
   logic       live;
   line_addr_t line_addr;

   assign live      = latched_req.re | (|latched_req.we);
   assign line_addr = {latched_req.addr.f.tag, latched_req.addr.f.set};

   // Look up the incoming set while idle, the held set while busy
   assign ram_set = ready ? cpu_req.addr.f.set : latched_req.addr.f.set;

   always_comb begin
      issue   = '0;
      fill_we = 1'b0;
      wr_we   = 1'b0;
      ready   = 1'b0;

      if (live & ~hit) begin
         // Miss: send the line read once, then wait for the fill data
         if (rd_pend) begin
            issue.valid = 1'b1;
            issue.opc   = l2_opc_read;
            issue.addr  = line_addr;
         end else if (l2_rvalid & ~l2_stall) begin
            fill_we = 1'b1;
         end
      end else if (wr_pend) begin
         // Line is resident, write through with the merged line
         issue.valid = 1'b1;
         issue.opc   = l2_opc_write;
         issue.addr  = line_addr;
         issue.wdata = merged_line;
         issue.wbe   = line_be;
         wr_we       = ~l2_stall;
      end else begin
         ready = 1'b1;
      end
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         latched_req <= '0;
         rd_pend     <= 1'b0;
         wr_pend     <= 1'b0;
      end else if (ready) begin
         latched_req <= cpu_req;
         rd_pend     <= 1'b1;
         wr_pend     <= |cpu_req.we;
      end else if (!l2_stall) begin
         // Only an accepted request clears its flag
         if (issue.valid && issue.opc == l2_opc_read) begin
            rd_pend <= 1'b0;
         end
         if (wr_we) begin
            wr_pend <= 1'b0;
         end
      end
   end

endmodule

//--- source/dcache_way_store.sv
module dcache_way_store (
   input  logic                             clkrst_mem_clk,
   input  logic                             clkrst_mem_rst_n,
   input  logic [dcache_pkg::set_width-1:0] ram_set,
   input  dcache_pkg::cpu_req_t             latched_req,
   input  logic                             fill_we,
   input  logic                             wr_we,
   input  logic                             victim_way,
   input  dcache_pkg::line_t                fill_line,
   input  dcache_pkg::line_t                merged_line,
   output logic                             hit,
   output logic                             hit_way,
   output dcache_pkg::line_t                hit_line,
   output logic [31:0]                      rd_word
);

   import dcache_pkg::*;

   line_t                              data_mem [num_ways][num_sets];
   logic [tag_width-1:0]               tag_mem  [num_ways][num_sets];
   line_t                              data_q   [num_ways];
   logic [tag_width-1:0]               tag_q    [num_ways];
   logic [num_ways-1:0][num_sets-1:0]  valid;
   logic [num_ways-1:0]                way_we;
   logic [num_ways-1:0]                way_hit;
   line_t                              way_wdata;

   // Fill goes to the victim, a write to the way that hit
   always_comb begin
      way_we = '0;
      if (fill_we) begin
         way_we[victim_way] = 1'b1;
      end else if (wr_we) begin
         way_we[hit_way] = 1'b1;
      end
   end

   assign way_wdata = fill_we ? fill_line : merged_line;

   // Single-port RAM, write-first so the new line is seen on the next cycle
   always_ff @(posedge clkrst_mem_clk) begin
      for (int w = 0; w < num_ways; w++) begin
         if (way_we[w]) begin
            data_mem[w][ram_set] <= way_wdata;
            tag_mem[w][ram_set]  <= latched_req.addr.f.tag;
            data_q[w]            <= way_wdata;
            tag_q[w]             <= latched_req.addr.f.tag;
         end else begin
            data_q[w] <= data_mem[w][ram_set];
            tag_q[w]  <= tag_mem[w][ram_set];
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         valid <= '0;
      end else if (fill_we) begin
         valid[victim_way][latched_req.addr.f.set] <= 1'b1;
      end
   end

   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         way_hit[w] = valid[w][latched_req.addr.f.set] &&
                      (tag_q[w] == latched_req.addr.f.tag);
      end
   end

   // With two ways the hit index is just whether way 1 hit
   assign hit      = |way_hit;
   assign hit_way  = way_hit[1];
   assign hit_line = data_q[hit_way];
   assign rd_word  = hit_line[{latched_req.addr.f.word_sel, 5'b0} +: 32];

endmodule

//--- source/dcache_line_merge.sv
module dcache_line_merge (
   input  dcache_pkg::line_t    hit_line,
   input  dcache_pkg::cpu_req_t latched_req,
   output dcache_pkg::line_t    merged_line,
   output dcache_pkg::line_be_t line_be
);

   import dcache_pkg::*;

   logic [31:0] bit_mask;
   line_t       line_mask;
   line_t       line_data;
   logic [7:0]  bit_shift;
   logic [4:0]  byte_shift;

   // One byte lane per enable bit
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         bit_mask[b*8 +: 8] = {8{latched_req.we[b]}};
      end
   end

   assign bit_shift  = {latched_req.addr.f.word_sel, 5'b0};
   assign byte_shift = {latched_req.addr.f.word_sel, 2'b0};

   assign line_mask = line_t'(bit_mask) << bit_shift;
   assign line_data = line_t'(latched_req.wdata & bit_mask) << bit_shift;

   // Keep the old bytes outside the mask
   assign merged_line = (hit_line & ~line_mask) | line_data;
   assign line_be     = line_be_t'(latched_req.we) << byte_shift;

endmodule

//--- source/dcache_replace.sv
module dcache_replace (
   input  logic                             clkrst_mem_clk,
   input  logic                             clkrst_mem_rst_n,
   input  logic [dcache_pkg::set_width-1:0] set,
   input  logic                             hit,
   input  logic                             hit_way,
   input  dcache_pkg::cpu_req_t             latched_req,
   output logic                             victim_way
);

   import dcache_pkg::*;

   // One bit per set naming the way to evict next
   logic [num_sets-1:0] victim;
   logic                live;

   assign live = latched_req.re | (|latched_req.we);

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         victim <= '0;
      end else if (live && hit) begin
         // The way just used stays, the other one goes next
         victim[set] <= ~hit_way;
      end
   end

   assign victim_way = victim[set];

endmodule

//--- source/dcache_l2_req.sv
module dcache_l2_req (
   input  logic                clkrst_mem_clk,
   input  logic                clkrst_mem_rst_n,
   input  dcache_pkg::l2_req_t issue,
   input  logic                l2_stall,
   output dcache_pkg::l2_req_t l2_req
);

   import dcache_pkg::*;

   logic       valid_q;
   l2_opc_t    opc_q;
   line_addr_t addr_q;
   line_t      wdata_q;
   line_be_t   wbe_q;

   // Valid is control state and comes up low
   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         valid_q <= 1'b0;
      end else if (!l2_stall) begin
         valid_q <= issue.valid;
      end
   end

   // Payload moves only with an accepted request, held under stall
   always_ff @(posedge clkrst_mem_clk) begin
      if (!l2_stall && issue.valid) begin
         opc_q   <= issue.opc;
         addr_q  <= issue.addr;
         wdata_q <= issue.wdata;
         wbe_q   <= issue.wbe;
      end
   end

   always_comb begin
      l2_req.valid = valid_q;
      l2_req.opc   = opc_q;
      l2_req.addr  = addr_q;
      l2_req.wdata = wdata_q;
      l2_req.wbe   = wbe_q;
   end

endmodule

//--- source/dcache_l1.sv
module dcache_l1 (
   input  logic                clkrst_mem_clk,
   input  logic                clkrst_mem_rst_n,

   // Processor side
   input  dcache_pkg::cpu_req_t cpu_req,
   output logic [31:0]         rd_word,
   output logic                ready,

   // Level-two arbiter side
   output dcache_pkg::l2_req_t  l2_req,
   input  dcache_pkg::line_t    l2_rdata,
   input  logic                l2_rvalid,
   input  logic                l2_stall
);

   import dcache_pkg::*;

   cpu_req_t               latched_req;
   logic [set_width-1:0]   ram_set;
   logic                   fill_we;
   logic                   wr_we;
   l2_req_t                issue;
   logic                   hit;
   logic                   hit_way;
   line_t                  hit_line;
   line_t                  merged_line;
   line_be_t               line_be;
   logic                   victim_way;

   dcache_ctrl u_ctrl (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .cpu_req          (cpu_req),
      .hit              (hit),
      .l2_rvalid        (l2_rvalid),
      .l2_stall         (l2_stall),
      .merged_line      (merged_line),
      .line_be          (line_be),
      .latched_req      (latched_req),
      .ram_set          (ram_set),
      .fill_we          (fill_we),
      .wr_we            (wr_we),
      .issue            (issue),
      .ready            (ready)
   );

   dcache_way_store u_way_store (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .ram_set          (ram_set),
      .latched_req      (latched_req),
      .fill_we          (fill_we),
      .wr_we            (wr_we),
      .victim_way       (victim_way),
      .fill_line        (l2_rdata),
      .merged_line      (merged_line),
      .hit              (hit),
      .hit_way          (hit_way),
      .hit_line         (hit_line),
      .rd_word          (rd_word)
   );

   dcache_line_merge u_line_merge (
      .hit_line    (hit_line),
      .latched_req (latched_req),
      .merged_line (merged_line),
      .line_be     (line_be)
   );

   dcache_replace u_replace (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .set              (latched_req.addr.f.set),
      .hit              (hit),
      .hit_way          (hit_way),
      .latched_req      (latched_req),
      .victim_way       (victim_way)
   );

   dcache_l2_req u_l2_req (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .issue            (issue),
      .l2_stall         (l2_stall),
      .l2_req           (l2_req)
   );

endmodule

//--- tests/dcache_l1_sva.sv
module dcache_l1_sva (
   input logic                clkrst_mem_clk,
   input logic                clkrst_mem_rst_n,
   input dcache_pkg::l2_req_t l2_req,
   input logic                l2_stall,
   input logic                ready
);
   timeunit 1ns;
   timeprecision 100ps;

   import dcache_pkg::*;

   // A request waiting on the arbiter must not move
   stall_hold: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      (l2_stall && l2_req.valid) |=> $stable(l2_req))
      else $error("l2_req changed while l2_stall was high");

   reset_idle: assert property (@(posedge clkrst_mem_clk)
      !clkrst_mem_rst_n |-> !l2_req.valid)
      else $error("l2_req.valid was high during reset");

   // A line read is presented for exactly one accepted cycle
   read_once: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      (l2_req.valid && l2_req.opc == l2_opc_read && !l2_stall) |=> !l2_req.valid)
      else $error("l2 read request stayed valid after it was accepted");

   // A line read still waiting on level two keeps the cache busy
   busy_on_read: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      (l2_req.valid && l2_req.opc == l2_opc_read) |-> !ready)
      else $error("ready was high while a line read was outstanding");

endmodule

bind dcache_l1 dcache_l1_sva u_sva (
   .clkrst_mem_clk   (clkrst_mem_clk),
   .clkrst_mem_rst_n (clkrst_mem_rst_n),
   .l2_req           (l2_req),
   .l2_stall         (l2_stall),
   .ready            (ready)
);

//--- tests/tb_dcache_l1.sv
module tb_dcache_l1;
   timeunit 1ns;
   timeprecision 100ps;

   import dcache_pkg::*;

   localparam int wait_limit = 200;

   logic        clkrst_mem_clk;
   logic        clkrst_mem_rst_n;
   cpu_req_t    cpu_req;
   logic [31:0] rd_word;
   logic        ready;
   l2_req_t     l2_req;
   line_t       l2_rdata  = '0;
   logic        l2_rvalid = 1'b0;
   logic        l2_stall  = 1'b0;

   // Level-two memory model state
   line_t       mem_lines [line_addr_t];
   line_addr_t  rd_addr;
   int          rd_wait   = 0;
   int          rd_count  = 0;
   int          wr_count  = 0;
   l2_req_t     last_read;
   l2_req_t     last_write;
   logic        stall_on;

   dcache_l1 u_dut (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .cpu_req          (cpu_req),
      .rd_word          (rd_word),
      .ready            (ready),
      .l2_req           (l2_req),
      .l2_rdata         (l2_rdata),
      .l2_rvalid        (l2_rvalid),
      .l2_stall         (l2_stall)
   );

   initial begin
      clkrst_mem_clk = 1'b0;
      forever #50 clkrst_mem_clk = ~clkrst_mem_clk;
   end

   // Untouched lines carry a pattern built from the full word address
   function automatic line_t backing_line(input line_addr_t addr);
      line_t result;
      if (mem_lines.exists(addr)) begin
         result = mem_lines[addr];
      end else begin
         for (int w = 0; w < 8; w++) begin
            result[w*32 +: 32] = {2'b10, addr, 3'(w)} ^ 32'hc3a5_1e0f;
         end
      end
      return result;
   endfunction

   function automatic line_t apply_wbe(input line_t line, input line_t wdata, input line_be_t wbe);
      line_t result;
      result = line;
      for (int b = 0; b < line_bytes; b++) begin
         if (wbe[b]) begin
            result[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return result;
   endfunction

   function automatic line_t put_bytes(input line_t line, input logic [2:0] ws,
                                       input byte_en_t we, input logic [31:0] wdata);
      line_t result;
      result = line;
      for (int b = 0; b < 4; b++) begin
         if (we[b]) begin
            result[(int'(ws) * 4 + b) * 8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return result;
   endfunction

   function automatic word_addr_t make_addr(input logic [22:0] tag, input logic [3:0] set,
                                            input logic [2:0] ws);
      word_addr_t a;
      a.word_addr = {tag, set, ws};
      return a;
   endfunction

   function automatic line_addr_t line_of(input word_addr_t a);
      return a.word_addr[29:3];
   endfunction

   function automatic logic [31:0] model_word(input word_addr_t a);
      line_t l;
      l = backing_line(line_of(a));
      return l[int'(a.word_addr[2:0]) * 32 +: 32];
   endfunction

   // Random arbiter back-pressure
   always @(posedge clkrst_mem_clk) begin
      if (!clkrst_mem_rst_n) begin
         l2_stall <= 1'b0;
      end else begin
         l2_stall <= stall_on && ($urandom % 3 == 0);
      end
   end

   // Level-two memory, a request counts once it is seen with stall low
   always @(posedge clkrst_mem_clk) begin
      if (!clkrst_mem_rst_n) begin
         l2_rvalid <= 1'b0;
         rd_wait = 0;
      end else begin
         if (l2_rvalid && !l2_stall) begin
            l2_rvalid <= 1'b0;
         end
         if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
               l2_rvalid <= 1'b1;
               l2_rdata  <= backing_line(rd_addr);
            end
         end
         if (l2_req.valid && !l2_stall) begin
            if (l2_req.opc == l2_opc_read) begin
               rd_count++;
               last_read = l2_req;
               rd_addr   = l2_req.addr;
               rd_wait   = 1 + int'($urandom % 4);
            end else begin
               wr_count++;
               last_write = l2_req;
               mem_lines[l2_req.addr] = apply_wbe(backing_line(l2_req.addr),
                                                  l2_req.wdata, l2_req.wbe);
            end
         end
      end
   end

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic compare_word(input string test_name, input logic [31:0] exp_word,
                               input logic [31:0] act_word);
      if (act_word !== exp_word) begin
         $display("** Error [%s] expected %h actual %h", test_name, exp_word, act_word);
         abort_run();
      end
   endtask

   task automatic compare_l2_req(input string test_name, input l2_req_t exp_req,
                                 input l2_req_t act_req);
      if (act_req !== exp_req) begin
         $display("** Error [%s] expected %h actual %h", test_name, exp_req, act_req);
         abort_run();
      end
   endtask

   task automatic compare_count(input string test_name, input int exp_cnt, input int act_cnt);
      if (act_cnt != exp_cnt) begin
         $display("** Error [%s] expected %0d actual %0d", test_name, exp_cnt, act_cnt);
         abort_run();
      end
   endtask

   task automatic wait_for_ready(input string test_name);
      int cycles;
      cycles = 0;
      @(negedge clkrst_mem_clk);
      while (!ready) begin
         cycles++;
         if (cycles > wait_limit) begin
            $display("Timeout in %s: ready did not rise within %0d cycles", test_name, wait_limit);
            abort_run();
         end
         @(negedge clkrst_mem_clk);
      end
   endtask

   task automatic wait_for_write(input string test_name, input int target);
      int cycles;
      cycles = 0;
      @(negedge clkrst_mem_clk);
      while (wr_count < target) begin
         cycles++;
         if (cycles > wait_limit) begin
            $display("Timeout in %s: the level-two write never arrived", test_name);
            abort_run();
         end
         @(negedge clkrst_mem_clk);
      end
      @(posedge clkrst_mem_clk);
   endtask

   // Starts and ends on a rising edge, the word is taken while ready is high
   task automatic access(input string test_name, input cpu_req_t req, output logic [31:0] word);
      cpu_req <= req;
      wait_for_ready(test_name);
      @(posedge clkrst_mem_clk);
      cpu_req <= '0;
      wait_for_ready(test_name);
      word = rd_word;
      @(posedge clkrst_mem_clk);
   endtask

   task automatic read_check(input string test_name, input word_addr_t addr, input int exp_reads);
      cpu_req_t    req;
      l2_req_t     exp_req;
      logic [31:0] word;
      int          rd_before;
      int          wr_before;
      req       = '0;
      req.re    = 1'b1;
      req.addr  = addr;
      rd_before = rd_count;
      wr_before = wr_count;
      access(test_name, req, word);
      compare_word(test_name, model_word(addr), word);
      compare_count({test_name, " reads"}, exp_reads, rd_count - rd_before);
      compare_count({test_name, " writes"}, 0, wr_count - wr_before);
      if (exp_reads == 1) begin
         exp_req       = '0;
         exp_req.valid = 1'b1;
         exp_req.opc   = l2_opc_read;
         exp_req.addr  = line_of(addr);
         compare_l2_req({test_name, " request"}, exp_req, last_read);
      end
   endtask

   task automatic write_check(input string test_name, input word_addr_t addr, input byte_en_t we,
                              input logic [31:0] wdata, input int exp_reads);
      cpu_req_t    req;
      l2_req_t     exp_req;
      logic [31:0] word;
      int          rd_before;
      int          wr_before;
      req       = '0;
      req.we    = we;
      req.addr  = addr;
      req.wdata = wdata;
      // Expected line is the model line before the write with the enabled bytes replaced
      exp_req       = '0;
      exp_req.valid = 1'b1;
      exp_req.opc   = l2_opc_write;
      exp_req.addr  = line_of(addr);
      exp_req.wdata = put_bytes(backing_line(line_of(addr)), addr.word_addr[2:0], we, wdata);
      for (int b = 0; b < 4; b++) begin
         if (we[b]) begin
            exp_req.wbe[int'(addr.word_addr[2:0]) * 4 + b] = 1'b1;
         end
      end
      rd_before = rd_count;
      wr_before = wr_count;
      access(test_name, req, word);
      wait_for_write(test_name, wr_before + 1);
      compare_count({test_name, " reads"}, exp_reads, rd_count - rd_before);
      compare_count({test_name, " writes"}, 1, wr_count - wr_before);
      compare_l2_req(test_name, exp_req, last_write);
   endtask

   task automatic check_after_reset();
      if (ready !== 1'b1) begin
         $display("ready is not high in the first cycle after reset");
         abort_run();
      end
      if (l2_req.valid !== 1'b0) begin
         $display("a level-two request is valid right after reset");
         abort_run();
      end
   endtask

   task automatic test_read_miss_hit();
      read_check("read_miss", make_addr(23'h12_3456, 4'd3, 3'd5), 1);
      read_check("read_hit", make_addr(23'h12_3456, 4'd3, 3'd5), 0);
   endtask

   task automatic test_byte_write();
      write_check("byte_write", make_addr(23'h12_3456, 4'd3, 3'd2), 4'b0110, 32'hdead_beef, 0);
      read_check("byte_write_read", make_addr(23'h12_3456, 4'd3, 3'd2), 0);
   endtask

   task automatic test_write_miss();
      write_check("write_miss", make_addr(23'h05_0a0b, 4'd7, 3'd7), 4'b1111, 32'h0123_4567, 1);
      read_check("write_miss_read", make_addr(23'h05_0a0b, 4'd7, 3'd7), 0);
   endtask

   // Three lines in set 9, order A B A C must push out B
   task automatic test_replacement();
      read_check("repl_a_miss", make_addr(23'h00_0a01, 4'd9, 3'd1), 1);
      read_check("repl_b_miss", make_addr(23'h00_0b02, 4'd9, 3'd4), 1);
      read_check("repl_a_hit", make_addr(23'h00_0a01, 4'd9, 3'd1), 0);
      read_check("repl_c_miss", make_addr(23'h00_0c03, 4'd9, 3'd6), 1);
      read_check("repl_a_kept", make_addr(23'h00_0a01, 4'd9, 3'd1), 0);
      read_check("repl_b_evicted", make_addr(23'h00_0b02, 4'd9, 3'd4), 1);
   endtask

   initial begin
      void'($urandom(32'hf735));
      cpu_req          = '0;
      clkrst_mem_rst_n = 1'b0;
      stall_on         = 1'b0;
      repeat (4) @(posedge clkrst_mem_clk);
      clkrst_mem_rst_n <= 1'b1;
      @(negedge clkrst_mem_clk);
      check_after_reset();
      @(posedge clkrst_mem_clk);
      stall_on <= 1'b1;
      test_read_miss_hit();
      test_byte_write();
      test_write_miss();
      test_replacement();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- dcache_l1.f
source/dcache_pkg.sv
source/dcache_ctrl.sv
source/dcache_way_store.sv
source/dcache_line_merge.sv
source/dcache_replace.sv
source/dcache_l2_req.sv
source/dcache_l1.sv
tests/dcache_l1_sva.sv
tests/tb_dcache_l1.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_dcache_l1
FILELIST  = dcache_l1.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Pass or fail is taken from the log, not from the simulator exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
